/* vlog.f */
+incdir+dv
hdl/fetch_pkg.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/imem_slave.sv
hdl/fetch_top.sv
dv/tb_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top tb_fetch -o tb_fetch_sim

# the pipe keeps going on a failing run so the log can be searched
./obj_dir/tb_fetch_sim 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation done"

/* dv/tb_model.svh */
/*
 * Reference model for the fetch front end testbench.
 * Classifies a word, works out a JAL target and the next PC
 * from the RV64 encoding rules. Included inside the testbench module.
 */

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// anything not ending in 11 is not a 32-bit encoding
function automatic ret_kind_e model_kind(input logic [INST_W-1:0] inst);
  logic [6:0] op;
  op = inst[6:0];
  if (inst[1:0] != 2'b11) return KIND_TRAP;
  if (op == OP_SYSTEM) return KIND_TRAP;
  if (op == OP_JAL) return KIND_JAL;
  return KIND_SEQ;
endfunction

// imm[20|10:1|11|19:12] sits in inst[31:12]
function automatic logic [XLEN-1:0] jal_target(input logic [XLEN-1:0] pc,
                                               input logic [INST_W-1:0] inst);
  logic [20:0]     imm;
  logic [XLEN-1:0] offset;
  imm[20]    = inst[31];
  imm[10:1]  = inst[30:21];
  imm[11]    = inst[20];
  imm[19:12] = inst[19:12];
  imm[0]     = 1'b0;
  offset = {{(XLEN-21){imm[20]}}, imm};
  return pc + offset;
endfunction

function automatic logic [XLEN-1:0] model_next_pc(input logic [XLEN-1:0] pc,
                                                  input logic [INST_W-1:0] inst);
  case (model_kind(inst))
    KIND_TRAP: return TRAP_VEC;
    KIND_JAL:  return jal_target(pc, inst);
    default:   return pc + 64'd4;
  endcase
endfunction

`endif

/* dv/tb_fetch.sv */
/*
 * Testbench for the fetch front end.
 * Loads a random program through the loader port, starts the core and
 * follows every retired word against a PC walk of the program copy,
 * with random back-pressure on the retire port.
 */

`timescale 1ns/100ps

module tb_fetch import fetch_pkg::*; ();

  localparam int          RESET_CYCLES = 10;
  localparam int          NUM_RETIRES  = 300;
  localparam int          TIMEOUT      = 200;
  localparam int unsigned SEED         = 32'h7194;

  logic               clk;
  logic               rst;
  logic               run;
  logic               load_valid;
  logic [IMEM_AW-1:0] load_addr;
  logic [INST_W-1:0]  load_data;
  logic               ret_valid;
  logic               ret_ready;
  logic [XLEN-1:0]    ret_pc;
  logic [INST_W-1:0]  ret_inst;
  ret_kind_e          ret_kind;

  logic [INST_W-1:0]  mem_copy [IMEM_DEPTH];
  int unsigned        seed_init;

  // stalled retire from the last cycle
  logic               held;
  logic [XLEN-1:0]    held_pc;
  logic [INST_W-1:0]  held_inst;
  ret_kind_e          held_kind;

  `include "tb_model.svh"

  fetch_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .ret_valid  (ret_valid),
    .ret_ready  (ret_ready),
    .ret_pc     (ret_pc),
    .ret_inst   (ret_inst),
    .ret_kind   (ret_kind)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("[ERROR] %0t: %s", $time, msg));
  endtask

  // about 70 % sequential, 20 % JAL, 10 % ECALL or illegal
  function automatic logic [INST_W-1:0] random_word();
    logic [INST_W-1:0] w;
    logic [20:0]       imm;
    logic [4:0]        rd;
    logic [6:0]        op;
    int                pick;
    int                offset;
    pick = int'($urandom_range(0, 99));
    w = $urandom;
    if (pick < 70) begin
      w[1:0] = 2'b11;
      if (w[6:0] == OP_JAL || w[6:0] == OP_SYSTEM) w[6:0] = 7'b0010011;
    end else if (pick < 90) begin
      // never zero, so a jump cannot spin on itself
      offset = int'($urandom_range(1, 32)) * 4;
      if ($urandom_range(0, 1) == 1) offset = -offset;
      imm = 21'(offset);
      rd = 5'($urandom_range(0, 31));
      op = OP_JAL;
      w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
    end else if (pick < 95) begin
      w = 32'h0000_0073;
    end else if (w[1:0] == 2'b11) begin
      w[1:0] = 2'b01;
    end
    return w;
  endfunction

  task automatic check_hold();
    assert (!held || (ret_valid && ret_pc == held_pc && ret_inst == held_inst &&
                      ret_kind == held_kind))
    else report_mismatch($sformatf("stalled retire changed, pc %h -> %h inst %h -> %h",
                                   held_pc, ret_pc, held_inst, ret_inst));
  endtask

  // one cycle per pass; returns once a retire handshake is set up
  task automatic wait_retire(output logic [XLEN-1:0] pc, output logic [INST_W-1:0] inst,
                             output ret_kind_e kind);
    int   cycles;
    logic done;
    cycles = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      #1;
      check_hold();
      ret_ready = ($urandom_range(0, 3) != 0);
      if (ret_valid && ret_ready) begin
        pc = ret_pc;
        inst = ret_inst;
        kind = ret_kind;
        done = 1'b1;
      end
      held = ret_valid && !ret_ready;
      held_pc = ret_pc;
      held_inst = ret_inst;
      held_kind = ret_kind;
      cycles++;
      if (!done && cycles >= TIMEOUT) begin
        abort_run($sformatf("timeout, nothing retired within %0d cycles", TIMEOUT));
      end
    end
  endtask

  initial begin
    logic [XLEN-1:0]   exp_pc;
    logic [INST_W-1:0] exp_inst;
    logic [XLEN-1:0]   got_pc;
    logic [INST_W-1:0] got_inst;
    ret_kind_e         got_kind;
    int                retired;
    int                n_jal;
    int                n_trap;
    logic [INST_W-1:0] w;

    clk = 1'b0;
    rst = 1'b1;
    run = 1'b0;
    load_valid = 1'b0;
    load_addr = '0;
    load_data = '0;
    ret_ready = 1'b0;
    held = 1'b0;
    retired = 0;
    n_jal = 0;
    n_trap = 0;
    seed_init = $urandom(SEED);

    // program load overlaps reset, then a few idle cycles before run
    for (int i = 0; i < IMEM_DEPTH + 10; i++) begin
      @(posedge clk);
      #1;
      if (i == RESET_CYCLES - 1) rst = 1'b0;
      if (i > RESET_CYCLES - 1) begin
        assert (!ret_valid)
        else report_mismatch("ret_valid high before run");
      end
      ret_ready = ($urandom_range(0, 3) != 0);
      load_valid = (i < IMEM_DEPTH);
      if (i < IMEM_DEPTH) begin
        w = random_word();
        mem_copy[i] = w;
        load_addr = IMEM_AW'(i);
        load_data = w;
      end
    end
    run = 1'b1;

    exp_pc = 64'h0000_0000_8000_0000;
    while (retired < NUM_RETIRES) begin
      wait_retire(got_pc, got_inst, got_kind);
      exp_inst = mem_copy[exp_pc[IMEM_AW+1:2]];
      assert (got_pc == exp_pc)
      else report_mismatch($sformatf("retire %0d pc %h, expected %h", retired, got_pc, exp_pc));
      assert (got_inst == exp_inst)
      else report_mismatch($sformatf("retire %0d inst %h, expected %h",
                                     retired, got_inst, exp_inst));
      assert (got_kind == model_kind(exp_inst))
      else report_mismatch($sformatf("retire %0d kind %0d, expected %0d",
                                     retired, got_kind, model_kind(exp_inst)));
      if (model_kind(exp_inst) == KIND_JAL) n_jal++;
      if (model_kind(exp_inst) == KIND_TRAP) n_trap++;
      exp_pc = model_next_pc(exp_pc, exp_inst);
      retired++;
    end

    $display("retired %0d words, %0d jal, %0d trap", retired, n_jal, n_trap);
    if (n_jal > 0 && n_trap > 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("program never reached both a JAL and a trap");
    end
  end

endmodule

/* hdl/fetch_top.sv */
/*
 * Fetch front end top level.
 * Wires the fetch stage, the decode/redirect stage and the instruction
 * memory together. The program is loaded through the loader port, run
 * starts fetching, and words leave on the retire port.
 */

`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,

  input  logic               load_valid,
  input  logic [IMEM_AW-1:0] load_addr,
  input  logic [INST_W-1:0]  load_data,

  output logic               ret_valid,
  input  logic               ret_ready,
  output logic [XLEN-1:0]    ret_pc,
  output logic [INST_W-1:0]  ret_inst,
  output ret_kind_e          ret_kind
);

  // fetch to decode
  logic              if_to_id_valid;
  logic [XLEN-1:0]   if_to_id_pc;
  logic [INST_W-1:0] if_to_id_inst;
  logic              id_allowin;

  // decode to fetch
  logic              if_bj_ready;
  logic              bj_valid;
  logic              bj_ena;
  logic [XLEN-1:0]   bj_pc;
  logic              excp_jmp_ena;
  logic [XLEN-1:0]   excp_pc;

  // instruction bus
  logic              ibus_valid;
  logic              ibus_ready;
  logic [XLEN-1:0]   ibus_addr;
  logic [XLEN-1:0]   ibus_data;

  if_stage i_if_stage (
    .clk            (clk),
    .rst            (rst),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_pc    (if_to_id_pc),
    .if_to_id_inst  (if_to_id_inst),
    .id_allowin     (id_allowin),
    .if_bj_ready    (if_bj_ready),
    .bj_valid       (bj_valid),
    .bj_ena         (bj_ena),
    .bj_pc          (bj_pc),
    .excp_jmp_ena   (excp_jmp_ena),
    .excp_pc        (excp_pc),
    .ibus_valid     (ibus_valid),
    .ibus_ready     (ibus_ready),
    .ibus_data      (ibus_data),
    .ibus_addr      (ibus_addr)
  );

  id_stage i_id_stage (
    .clk            (clk),
    .rst            (rst),
    .run            (run),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_pc    (if_to_id_pc),
    .if_to_id_inst  (if_to_id_inst),
    .id_allowin     (id_allowin),
    .if_bj_ready    (if_bj_ready),
    .bj_valid       (bj_valid),
    .bj_ena         (bj_ena),
    .bj_pc          (bj_pc),
    .excp_jmp_ena   (excp_jmp_ena),
    .excp_pc        (excp_pc),
    .ret_valid      (ret_valid),
    .ret_ready      (ret_ready),
    .ret_pc         (ret_pc),
    .ret_inst       (ret_inst),
    .ret_kind       (ret_kind)
  );

  imem_slave i_imem_slave (
    .clk        (clk),
    .rst        (rst),
    .ibus_valid (ibus_valid),
    .ibus_ready (ibus_ready),
    .ibus_addr  (ibus_addr),
    .ibus_data  (ibus_data),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

endmodule

/* hdl/imem_slave.sv */
/*
 * Instruction memory slave on the fetch bus.
 * Word array filled through a write-only loader port. Reads answer
 * after 0 to 3 wait states picked by a free-running LFSR; the word is
 * registered at the handshake and zero-extended to the bus width.
 */

`timescale 1ns/100ps

module imem_slave import fetch_pkg::*; (
  input  logic               clk,
  input  logic               rst,

  // instruction bus
  input  logic               ibus_valid,
  output logic               ibus_ready,
  input  logic [XLEN-1:0]    ibus_addr,
  output logic [XLEN-1:0]    ibus_data,

  // loader
  input  logic               load_valid,
  input  logic [IMEM_AW-1:0] load_addr,
  input  logic [INST_W-1:0]  load_data
);

  logic [INST_W-1:0]  mem [IMEM_DEPTH];
  logic [3:0]         lfsr_q;
  logic               busy_q;
  logic [1:0]         wait_q;
  logic [IMEM_AW-1:0] rd_idx;
  logic               bus_hs;

  // upper address bits dropped, so the space wraps
  assign rd_idx = ibus_addr[IMEM_AW+1:2];

  // a fresh request may be ready at once, otherwise after the countdown
  assign ibus_ready = busy_q ? (wait_q == 2'd0) : (ibus_valid && lfsr_q[1:0] == 2'd0);
  assign bus_hs     = ibus_valid && ibus_ready;

  // x^4 + x^3 + 1
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q <= 4'b0001;
    end else begin
      lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      wait_q <= 2'd0;
    end else if (bus_hs) begin
      busy_q <= 1'b0;
    end else if (!busy_q && ibus_valid) begin
      busy_q <= 1'b1;
      wait_q <= lfsr_q[1:0] - 2'd1;
    end else if (busy_q && wait_q != 2'd0) begin
      wait_q <= wait_q - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_valid) begin
      mem[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clk) begin
    if (bus_hs) begin
      ibus_data <= {{(XLEN-INST_W){1'b0}}, mem[rd_idx]};
    end
  end

  // master keeps valid up until the handshake
  a_ready_needs_valid: assert property (
    @(posedge clk) disable iff (rst)
    ibus_ready |-> ibus_valid
  );

endmodule

/* hdl/id_stage.sv */
/*
 * Decode and redirect stage.
 * Holds one fetched word, classifies it as sequential, JAL or trap,
 * retires it on the output port and returns the next-PC grant to fetch
 * in the same cycle. Issues one kick-off grant once run is seen.
 */

`timescale 1ns/100ps

module id_stage import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,

  // pipeline from fetch
  input  logic              if_to_id_valid,
  input  logic [XLEN-1:0]   if_to_id_pc,
  input  logic [INST_W-1:0] if_to_id_inst,
  output logic              id_allowin,

  // next-PC grant to fetch
  input  logic              if_bj_ready,
  output logic              bj_valid,
  output logic              bj_ena,
  output logic [XLEN-1:0]   bj_pc,
  output logic              excp_jmp_ena,
  output logic [XLEN-1:0]   excp_pc,

  // retire port
  output logic              ret_valid,
  input  logic              ret_ready,
  output logic [XLEN-1:0]   ret_pc,
  output logic [INST_W-1:0] ret_inst,
  output ret_kind_e         ret_kind
);

  logic              id_valid_q;
  logic              started_q;
  logic [XLEN-1:0]   id_pc_q;
  logic [INST_W-1:0] id_inst_q;
  opcode_e           opcode;
  ret_kind_e         kind;
  logic [XLEN-1:0]   j_imm;
  logic              kick;
  logic              retire;
  logic              grant;

  assign opcode = opcode_e'(id_inst_q[6:0]);

  // compressed or otherwise non-32-bit encodings trap as illegal
  always_comb begin
    if (id_inst_q[1:0] != 2'b11) begin
      kind = KIND_TRAP;
    end else if (opcode == OP_SYSTEM) begin
      kind = KIND_TRAP;
    end else if (opcode == OP_JAL) begin
      kind = KIND_JAL;
    end else begin
      kind = KIND_SEQ;
    end
  end

  // J-type immediate, bit 0 always zero
  assign j_imm = {{(XLEN-20){id_inst_q[31]}}, id_inst_q[19:12], id_inst_q[20],
                  id_inst_q[30:21], 1'b0};

  assign kick   = run && !started_q;
  assign ret_valid = id_valid_q && if_bj_ready;
  assign retire = ret_valid && ret_ready;
  assign grant  = bj_valid && if_bj_ready;

  assign id_allowin = !id_valid_q || retire;

  // held word only grants while the retire port can take it
  assign bj_valid     = kick || (id_valid_q && ret_ready);
  assign bj_ena       = id_valid_q && (kind == KIND_JAL);
  assign bj_pc        = id_pc_q + j_imm;
  assign excp_jmp_ena = id_valid_q && (kind == KIND_TRAP);
  assign excp_pc      = TRAP_VEC;

  assign ret_pc   = id_pc_q;
  assign ret_inst = id_inst_q;
  assign ret_kind = kind;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid_q <= 1'b0;
      started_q  <= 1'b0;
    end else begin
      if (id_allowin) begin
        id_valid_q <= if_to_id_valid;
      end
      if (kick && grant) begin
        started_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (id_allowin && if_to_id_valid) begin
      id_pc_q   <= if_to_id_pc;
      id_inst_q <= if_to_id_inst;
    end
  end

  // a stalled retire stays offered and keeps its word
  a_ret_stable: assert property (
    @(posedge clk) disable iff (rst)
    ret_valid && !ret_ready |=> ret_valid && $stable(ret_pc) && $stable(ret_inst)
  );

endmodule

/* hdl/if_stage.sv */
/*
 * Instruction fetch stage.
 * Waits in IDLE for a next-PC grant from decode, issues one word read
 * on the instruction bus, then hands the returned word and its PC to
 * decode through a valid/allowin pipeline register.
 */

`timescale 1ns/100ps

module if_stage import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  // pipeline to decode
  output logic              if_to_id_valid,
  output logic [XLEN-1:0]   if_to_id_pc,
  output logic [INST_W-1:0] if_to_id_inst,
  input  logic              id_allowin,

  // next-PC grant from decode
  output logic              if_bj_ready,
  input  logic              bj_valid,
  input  logic              bj_ena,
  input  logic [XLEN-1:0]   bj_pc,
  input  logic              excp_jmp_ena,
  input  logic [XLEN-1:0]   excp_pc,

  // instruction bus
  output logic              ibus_valid,
  input  logic              ibus_ready,
  input  logic [XLEN-1:0]   ibus_data,
  output logic [XLEN-1:0]   ibus_addr
);

  if_state_e         state_q;
  if_state_e         state_d;
  logic [XLEN-1:0]   next_pc;
  logic              bj_hs;
  logic              bus_hs;
  logic              if_allowin;
  logic              if_accept;
  logic              if_valid_q;
  logic [XLEN-1:0]   if_pc_q;
  logic [INST_W-1:0] if_inst_q;

  assign if_bj_ready = (state_q == IDLE);
  assign ibus_valid  = (state_q == ADDR);
  assign bj_hs       = bj_valid && if_bj_ready;
  assign bus_hs      = ibus_valid && ibus_ready;

  // output register can take a word when empty or when decode drains it
  assign if_allowin = !if_valid_q || id_allowin;
  assign if_accept  = (state_q == RETN) && if_allowin;

  // exception first, then taken jump, else fall through
  assign next_pc = excp_jmp_ena ? excp_pc :
                   bj_ena       ? bj_pc   :
                   if_pc_q + 64'd4;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (bj_hs) state_d = ADDR;
      ADDR:    if (bus_hs) state_d = RETN;
      RETN:    if (if_accept) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // address follows the grant inputs while idle, frozen from ADDR on
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      ibus_addr <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      if_valid_q <= 1'b0;
    end else if (if_allowin) begin
      if_valid_q <= (state_q == RETN);
    end
  end

  // PC of the last fetched word; seeds the sequential next PC
  always_ff @(posedge clk) begin
    if (rst) begin
      if_pc_q <= RESET_PC;
    end else if (if_accept) begin
      if_pc_q <= ibus_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (if_accept) begin
      if_inst_q <= ibus_data[INST_W-1:0];
    end
  end

  assign if_to_id_valid = if_valid_q;
  assign if_to_id_pc    = if_pc_q;
  assign if_to_id_inst  = if_inst_q;

  // request address must hold until the slave takes it
  a_addr_stable: assert property (
    @(posedge clk) disable iff (rst)
    ibus_valid && !ibus_ready |=> $stable(ibus_addr)
  );

endmodule

/* hdl/fetch_pkg.sv */
/*
 * Shared constants and types for the instruction-fetch front end.
 * Imported by every RTL module and by the testbench model.
 * Holds bus widths, the reset PC, the trap vector, memory size
 * and the enums for the fetch FSM, opcodes and retire kinds.
 */

package fetch_pkg;

  // datapath widths
  localparam int XLEN   = 64;
  localparam int INST_W = 32;

  // one word below the boot address, so the first fetch lands on 0x80000000
  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_7fff_fffc;

  // fixed exception target
  localparam logic [XLEN-1:0] TRAP_VEC = 64'h0000_0000_8000_0100;

  // instruction memory, word indexed
  localparam int IMEM_AW    = 8;
  localparam int IMEM_DEPTH = 1 << IMEM_AW;

  // fetch FSM
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    ADDR = 2'b01,
    RETN = 2'b10
  } if_state_e;

  // major opcodes the decoder cares about
  typedef enum logic [6:0] {
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // classification of a retired word
  typedef enum logic [1:0] {
    KIND_SEQ  = 2'b00,
    KIND_JAL  = 2'b01,
    KIND_TRAP = 2'b10
  } ret_kind_e;

endpackage
